// ==== common/rfa_cfg.svh ====
`ifndef RFA_CFG_SVH
`define RFA_CFG_SVH

// Vector unit counts, SIMD queues come first in every index
`define RFA_NUM_SIMD 4
`define RFA_NUM_SIMF 4
`define RFA_NUM_FU (`RFA_NUM_SIMD + `RFA_NUM_SIMF)

// Entries per write-back queue
`define RFA_QUEUE_DEPTH 4

// Register file write fields
`define RFA_ADDR_W 10
`define RFA_DATA_W 32
`define RFA_WFID_W 6

// Source select word sent along with each write
`define RFA_SEL_W 16

`endif

// ==== common/rfa_pkg.sv ====
`default_nettype none

`include "rfa_cfg.svh"

package rfa_pkg;

   // One result waiting for its register file write
   typedef struct packed {
      logic [`RFA_ADDR_W-1:0] addr;
      logic [`RFA_DATA_W-1:0] data;
      logic [`RFA_WFID_W-1:0] wfid;
   } wb_entry_t;

   // Write towards the register file
   typedef struct packed {
      logic      we;
      wb_entry_t entry;
   } rf_write_t;

   localparam int SEL_RSVD_W = `RFA_SEL_W - 2 - `RFA_NUM_SIMF - `RFA_NUM_SIMD;

   // Field layout of the select word, MSB first
   typedef struct packed {
      logic [SEL_RSVD_W-1:0]    reserved;
      logic                     salu;
      logic                     lsu;
      logic [`RFA_NUM_SIMF-1:0] simf;
      logic [`RFA_NUM_SIMD-1:0] simd;
   } fu_select_s;

   // Built through the fields, checked as one flat word
   typedef union packed {
      logic [`RFA_SEL_W-1:0] flat;
      fu_select_s            fields;
   } fu_select_u;

endpackage

`default_nettype wire

// ==== wb_queue/wb_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module wb_queue (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              push,
   input  rfa_pkg::wb_entry_t     push_entry,
   input  wire logic              serviced,
   output logic                   valid,
   output rfa_pkg::wb_entry_t     head,
   output logic                   full
);

   localparam int DEPTH = `RFA_QUEUE_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

   rfa_pkg::wb_entry_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign valid = (count != '0);
   assign full  = (count == FULL_CNT);
   assign head  = mem[rd_ptr];

   // Pop only what is there; a full queue still takes a push if it pops too
   assign do_pop  = serviced & valid;
   assign do_push = push & (~full | do_pop);

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rfa/rfa.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module rfa (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic [`RFA_NUM_FU-1:0] entry_valid,
   input  wire logic                   lsu_dest_wr_req,
   input  wire logic                   salu_req,
   output logic      [`RFA_NUM_FU-1:0] entry_serviced,
   output logic                        lsu_grant,
   output logic                        salu_grant,
   output logic                        lsu_wait
);

   localparam int N     = `RFA_NUM_FU;
   localparam int IDX_W = $clog2(N);
   localparam logic [IDX_W:0]   N_WIDE  = (IDX_W + 1)'(N);
   localparam logic [IDX_W-1:0] LAST_Q  = IDX_W'(N - 1);

   logic [IDX_W-1:0] rr_ptr;
   logic [N-1:0]     masked_valid;
   logic [2*N-1:0]   doubled_valid;
   logic [N-1:0]     rotated_valid;
   logic [IDX_W-1:0] offset;
   logic             vec_win;
   logic [IDX_W:0]   winner_sum;
   logic [IDX_W-1:0] winner;
   logic [IDX_W-1:0] next_ptr;

   // SALU beats everything, LSU beats the vector queues
   assign masked_valid = entry_valid & {N{~(salu_req | lsu_dest_wr_req)}};
   assign salu_grant   = salu_req;
   assign lsu_grant    = lsu_dest_wr_req & ~salu_req;
   assign lsu_wait     = salu_req;

   // Rotate so the pointer position lands on bit 0
   assign doubled_valid = {masked_valid, masked_valid};
   assign rotated_valid = doubled_valid[rr_ptr +: N];

   // Lowest set bit of the rotated valids
   always_comb begin
      vec_win = 1'b0;
      offset  = '0;
      for (int j = 0; j < N; j++) begin
         if (!vec_win && rotated_valid[j]) begin
            vec_win = 1'b1;
            offset  = IDX_W'(j);
         end
      end
   end

   // Undo the rotation, modulo the queue count
   assign winner_sum = {1'b0, offset} + {1'b0, rr_ptr};
   assign winner     = (winner_sum >= N_WIDE) ? IDX_W'(winner_sum - N_WIDE)
                                              : IDX_W'(winner_sum);
   assign next_ptr   = (winner == LAST_Q) ? '0 : winner + 1'b1;

   always_comb begin
      entry_serviced = '0;
      if (vec_win) begin
         entry_serviced[winner] = 1'b1;
      end
   end

   // Pointer moves only on a vector grant
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rr_ptr <= '0;
      end else if (vec_win) begin
         rr_ptr <= next_ptr;
      end
   end

endmodule

`default_nettype wire

// ==== src/rf_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module rf_write_port (
   input  wire logic                            clk,
   input  wire logic                            rst_n,
   input  wire logic [`RFA_NUM_FU-1:0]          entry_serviced,
   input  wire logic                            lsu_grant,
   input  wire logic                            salu_grant,
   input  rfa_pkg::wb_entry_t [`RFA_NUM_FU-1:0] queue_head,
   input  rfa_pkg::wb_entry_t                   lsu_entry,
   input  rfa_pkg::wb_entry_t                   salu_entry,
   output rfa_pkg::rf_write_t                   rf_write,
   output rfa_pkg::fu_select_u                  select_fu
);

   rfa_pkg::wb_entry_t  vec_entry;
   rfa_pkg::wb_entry_t  win_entry;
   rfa_pkg::wb_entry_t  entry_q;
   rfa_pkg::fu_select_u sel_d;
   logic                we_d;
   logic                we_q;

   // Serviced is one-hot, so an AND-OR mux is enough
   always_comb begin
      vec_entry = '0;
      for (int i = 0; i < `RFA_NUM_FU; i++) begin
         vec_entry = vec_entry | (queue_head[i] & {$bits(rfa_pkg::wb_entry_t){entry_serviced[i]}});
      end
   end

   assign win_entry = salu_grant ? salu_entry :
                      lsu_grant  ? lsu_entry  : vec_entry;
   assign we_d      = salu_grant | lsu_grant | (|entry_serviced);

   // Select word, one bit per source
   always_comb begin
      sel_d.fields.reserved = '0;
      sel_d.fields.salu     = salu_grant;
      sel_d.fields.lsu      = lsu_grant;
      sel_d.fields.simf     = entry_serviced[`RFA_NUM_FU-1:`RFA_NUM_SIMD];
      sel_d.fields.simd     = entry_serviced[`RFA_NUM_SIMD-1:0];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         we_q      <= 1'b0;
         select_fu <= '0;
      end else begin
         we_q      <= we_d;
         select_fu <= sel_d;
      end
   end

   // Payload only
   always_ff @(posedge clk) begin
      if (we_d) begin
         entry_q <= win_entry;
      end
   end

   assign rf_write.we    = we_q;
   assign rf_write.entry = entry_q;

endmodule

`default_nettype wire

// ==== src/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module wb_top (
   input  wire logic                            clk,
   input  wire logic                            rst_n,
   // Vector unit results
   input  wire logic [`RFA_NUM_FU-1:0]          fu_push,
   input  rfa_pkg::wb_entry_t [`RFA_NUM_FU-1:0] fu_result,
   output logic      [`RFA_NUM_FU-1:0]          queue_full,
   // LSU write path
   input  wire logic                            lsu_dest_wr_req,
   input  rfa_pkg::wb_entry_t                   lsu_entry,
   output logic                                 lsu_wait,
   // SALU write path
   input  wire logic                            salu_req,
   input  rfa_pkg::wb_entry_t                   salu_entry,
   // Register file write
   output rfa_pkg::rf_write_t                   rf_write,
   output rfa_pkg::fu_select_u                  select_fu
);

   logic [`RFA_NUM_FU-1:0]          entry_valid;
   logic [`RFA_NUM_FU-1:0]          entry_serviced;
   rfa_pkg::wb_entry_t [`RFA_NUM_FU-1:0] queue_head;
   logic                            lsu_grant;
   logic                            salu_grant;

   // SIMD queues 0..3, SIMF queues 4..7
   for (genvar i = 0; i < `RFA_NUM_FU; i++) begin : g_queue
      wb_queue i_wb_queue (
         .clk        (clk),
         .rst_n      (rst_n),
         .push       (fu_push[i]),
         .push_entry (fu_result[i]),
         .serviced   (entry_serviced[i]),
         .valid      (entry_valid[i]),
         .head       (queue_head[i]),
         .full       (queue_full[i])
      );
   end

   rfa i_rfa (
      .clk             (clk),
      .rst_n           (rst_n),
      .entry_valid     (entry_valid),
      .lsu_dest_wr_req (lsu_dest_wr_req),
      .salu_req        (salu_req),
      .entry_serviced  (entry_serviced),
      .lsu_grant       (lsu_grant),
      .salu_grant      (salu_grant),
      .lsu_wait        (lsu_wait)
   );

   // One write per cycle, a cycle after the grant
   rf_write_port i_rf_write_port (
      .clk            (clk),
      .rst_n          (rst_n),
      .entry_serviced (entry_serviced),
      .lsu_grant      (lsu_grant),
      .salu_grant     (salu_grant),
      .queue_head     (queue_head),
      .lsu_entry      (lsu_entry),
      .salu_entry     (salu_entry),
      .rf_write       (rf_write),
      .select_fu      (select_fu)
   );

endmodule

`default_nettype wire

// ==== verification/wb_tb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module wb_tb_sva (
   input wire logic                   clk,
   input wire logic                   rst_n,
   input wire logic [`RFA_NUM_FU-1:0] fu_push,
   input wire logic [`RFA_NUM_FU-1:0] queue_full,
   input wire logic [`RFA_NUM_FU-1:0] entry_valid,
   input wire logic [`RFA_NUM_FU-1:0] entry_serviced,
   input wire logic                   lsu_dest_wr_req,
   input wire rfa_pkg::wb_entry_t     lsu_entry,
   input wire logic                   lsu_grant,
   input wire logic                   lsu_wait,
   input wire logic                   salu_req,
   input wire rfa_pkg::wb_entry_t     salu_entry,
   input wire logic                   salu_grant,
   input wire rfa_pkg::rf_write_t     rf_write,
   input wire rfa_pkg::fu_select_u    select_fu
);

   localparam int N      = `RFA_NUM_FU;
   localparam int IDX_W  = $clog2(N);
   localparam int RSVD_W = rfa_pkg::SEL_RSVD_W;
   localparam int DEPTH  = `RFA_QUEUE_DEPTH;
   localparam int CNT_W  = $clog2(DEPTH + 1);

   int                      fail_count = 0;
   logic [N-1:0][15:0]      exp_seq;
   logic [IDX_W-1:0]        rr_model;
   logic [N-1:0]            rr_expect;
   logic [N-1:0]            wr_units;
   logic [IDX_W-1:0]        wr_unit;
   logic [`RFA_DATA_W-1:0]  exp_data;
   logic                    any_grant;
   logic [N-1:0][CNT_W-1:0] occ_model;
   logic [N-1:0]            full_model;
   logic [N-1:0]            valid_model;

   function automatic logic [IDX_W-1:0] low_index(input logic [N-1:0] v);
      logic [IDX_W-1:0] idx;
      idx = '0;
      for (int j = N - 1; j >= 0; j--) begin
         if (v[j]) begin
            idx = IDX_W'(j);
         end
      end
      return idx;
   endfunction

   // First valid queue at or after start with wrap-around
   function automatic logic [N-1:0] first_valid_from(input logic [N-1:0] v,
                                                     input logic [IDX_W-1:0] start);
      logic [N-1:0]     pick;
      logic [IDX_W-1:0] idx;
      pick = '0;
      for (int j = N - 1; j >= 0; j--) begin
         idx = start + IDX_W'(j);
         if (v[idx]) begin
            pick      = '0;
            pick[idx] = 1'b1;
         end
      end
      return pick;
   endfunction

   assign any_grant = (|entry_serviced) | lsu_grant | salu_grant;
   assign rr_expect = first_valid_from(entry_valid, rr_model);
   assign wr_units  = {select_fu.fields.simf, select_fu.fields.simd};
   assign wr_unit   = low_index(wr_units);
   assign exp_data  = {8'(wr_unit), 8'h00, exp_seq[wr_unit]};

   // Expected queue levels from the occupancy model
   always_comb begin
      for (int i = 0; i < N; i++) begin
         full_model[i]  = (occ_model[i] == CNT_W'(DEPTH));
         valid_model[i] = (occ_model[i] != '0);
      end
   end

   // Pointer, sequence and occupancy models
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rr_model  <= '0;
         exp_seq   <= '0;
         occ_model <= '0;
      end else begin
         if (|entry_serviced) begin
            rr_model <= low_index(entry_serviced) + 1'b1;
         end
         if (rf_write.we && (wr_units != '0)) begin
            exp_seq[wr_unit] <= exp_seq[wr_unit] + 16'd1;
         end
         for (int i = 0; i < N; i++) begin
            occ_model[i] <= occ_model[i] + CNT_W'(fu_push[i]) - CNT_W'(entry_serviced[i]);
         end
      end
   end

   a_serviced_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(entry_serviced))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] entry_serviced 0x%h is not one-hot", entry_serviced);
      end

   a_bypass_blocks_vector: assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_dest_wr_req || salu_req) |-> (entry_serviced == '0))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] entry_serviced 0x%h during a bypass request", entry_serviced);
      end

   a_bypass_grants: assert property (@(posedge clk) disable iff (!rst_n)
      (salu_grant == salu_req) && (lsu_wait == salu_req) &&
      (lsu_grant == (lsu_dest_wr_req && !salu_req)))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] salu_grant 0x%h lsu_grant 0x%h lsu_wait 0x%h for requests 0x%h 0x%h",
                salu_grant, lsu_grant, lsu_wait, salu_req, lsu_dest_wr_req);
      end

   a_write_follows_grant: assert property (@(posedge clk) disable iff (!rst_n)
      any_grant |=> rf_write.we && $onehot(select_fu.flat) &&
      (select_fu.flat == {{RSVD_W{1'b0}}, $past(salu_grant), $past(lsu_grant),
                          $past(entry_serviced)}))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] rf_write.we 0x%h select_fu 0x%h after a grant",
                rf_write.we, select_fu.flat);
      end

   a_write_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
      !any_grant |=> !rf_write.we && (select_fu.flat == '0))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] rf_write.we 0x%h select_fu 0x%h without a grant",
                rf_write.we, select_fu.flat);
      end

   a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
      (!lsu_dest_wr_req && !salu_req) |-> (entry_serviced == rr_expect))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] entry_serviced 0x%h, expected 0x%h", entry_serviced, rr_expect);
      end

   a_unit_order: assert property (@(posedge clk) disable iff (!rst_n)
      (rf_write.we && (wr_units != '0)) |-> (rf_write.entry.data == exp_data))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] rf_write.entry.data 0x%h, expected 0x%h",
                rf_write.entry.data, exp_data);
      end

   a_bypass_data: assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_grant || salu_grant) |=>
      (rf_write.entry == $past(salu_grant ? salu_entry : lsu_entry)))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] rf_write.entry 0x%h does not match the bypass entry", rf_write.entry);
      end

   a_reset_clear: assert property (@(posedge clk)
      !rst_n |=> (!rf_write.we && (select_fu.flat == '0)))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] rf_write.we 0x%h select_fu 0x%h after reset",
                rf_write.we, select_fu.flat);
      end

   a_queue_level: assert property (@(posedge clk) disable iff (!rst_n)
      (queue_full == full_model) && (entry_valid == valid_model))
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] queue_full 0x%h entry_valid 0x%h, expected 0x%h 0x%h",
                queue_full, entry_valid, full_model, valid_model);
      end

   a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      (fu_push & queue_full) == '0)
      else begin
         fail_count = fail_count + 1;
         $error("[FAIL] fu_push 0x%h while queue_full 0x%h", fu_push, queue_full);
      end

endmodule

bind wb_top wb_tb_sva i_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .fu_push         (fu_push),
   .queue_full      (queue_full),
   .entry_valid     (entry_valid),
   .entry_serviced  (entry_serviced),
   .lsu_dest_wr_req (lsu_dest_wr_req),
   .lsu_entry       (lsu_entry),
   .lsu_grant       (lsu_grant),
   .lsu_wait        (lsu_wait),
   .salu_req        (salu_req),
   .salu_entry      (salu_entry),
   .salu_grant      (salu_grant),
   .rf_write        (rf_write),
   .select_fu       (select_fu)
);

`default_nettype wire

// ==== verification/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rfa_cfg.svh"

module wb_tb;

   localparam int N             = `RFA_NUM_FU;
   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 5;
   localparam int BUSY_CYCLES   = 300;
   localparam int SPARSE_CYCLES = 120;
   localparam int LSU_CYCLES    = 100;
   localparam int SALU_CYCLES   = 100;
   localparam int DRAIN_CYCLES  = 60;
   localparam int PHASE_CYCLES  = RESET_CYCLES + BUSY_CYCLES + SPARSE_CYCLES +
                                  LSU_CYCLES + SALU_CYCLES + DRAIN_CYCLES;
   localparam int TIMEOUT_NS    = PHASE_CYCLES * 2 * CLK_PERIOD;
   localparam int SPARSE_UNIT   = 5;

   logic                       clk;
   logic                       rst_n;
   logic [N-1:0]               fu_push;
   rfa_pkg::wb_entry_t [N-1:0] fu_result;
   logic [N-1:0]               queue_full;
   logic                       lsu_dest_wr_req;
   rfa_pkg::wb_entry_t         lsu_entry;
   logic                       lsu_wait;
   logic                       salu_req;
   rfa_pkg::wb_entry_t         salu_entry;
   rfa_pkg::rf_write_t         rf_write;
   rfa_pkg::fu_select_u        select_fu;

   integer                     seed;
   logic [N-1:0][15:0]         push_seq;
   logic                       end_ok;

   wb_top i_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .fu_push         (fu_push),
      .fu_result       (fu_result),
      .queue_full      (queue_full),
      .lsu_dest_wr_req (lsu_dest_wr_req),
      .lsu_entry       (lsu_entry),
      .lsu_wait        (lsu_wait),
      .salu_req        (salu_req),
      .salu_entry      (salu_entry),
      .rf_write        (rf_write),
      .select_fu       (select_fu)
   );

   // Unit index in the top byte, sequence number in the low half
   function automatic rfa_pkg::wb_entry_t unit_result(input int unit, input logic [15:0] seq,
                                                      input logic [31:0] r);
      rfa_pkg::wb_entry_t e;
      e.addr = r[31 -: `RFA_ADDR_W];
      e.data = {8'(unit), 8'h00, seq};
      e.wfid = r[0 +: `RFA_WFID_W];
      return e;
   endfunction

   function automatic rfa_pkg::wb_entry_t random_entry(input logic [31:0] r,
                                                       input logic [31:0] r2);
      rfa_pkg::wb_entry_t e;
      e.addr = r[0 +: `RFA_ADDR_W];
      e.data = r2;
      e.wfid = r[16 +: `RFA_WFID_W];
      return e;
   endfunction

   task automatic stop_on_failure(input string reason);
      $display("Error: %s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   // One cycle gap after each push keeps a unit clear of a full queue
   task automatic run_phase(input int cycles, input logic [N-1:0] active, input int odds,
                            input logic use_lsu, input logic use_salu);
      logic [31:0] r;
      logic [31:0] r2;
      logic        lsu_next;
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk);
         for (int i = 0; i < N; i++) begin
            r = $random(seed);
            if (active[i] && !queue_full[i] && !fu_push[i] && (int'(r[3:0]) < odds)) begin
               fu_push[i]   <= 1'b1;
               fu_result[i] <= unit_result(i, push_seq[i], r);
               push_seq[i]  = push_seq[i] + 16'd1;
            end else begin
               fu_push[i] <= 1'b0;
            end
         end
         // LSU holds its request while lsu_wait is up
         lsu_next = use_lsu && ((c % 16) < 10);
         lsu_dest_wr_req <= lsu_wait ? lsu_dest_wr_req : lsu_next;
         salu_req        <= use_salu && ((c % 16) >= 6) && ((c % 16) < 12);
         r  = $random(seed);
         r2 = $random(seed);
         lsu_entry  <= random_entry(r, r2);
         r  = $random(seed);
         r2 = $random(seed);
         salu_entry <= random_entry(r, r2);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      stop_on_failure("the run timed out before the drain finished");
   end

   initial begin
      while (i_dut.i_sva.fail_count == 0) begin
         @(negedge clk);
      end
      stop_on_failure("an assertion on the DUT failed");
   end

   initial begin
      seed            = 39429;
      rst_n           = 1'b0;
      fu_push         = '0;
      fu_result       = '0;
      lsu_dest_wr_req = 1'b0;
      lsu_entry       = '0;
      salu_req        = 1'b0;
      salu_entry      = '0;
      push_seq        = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      run_phase(BUSY_CYCLES, '1, 16, 1'b0, 1'b0);
      run_phase(SPARSE_CYCLES, N'(1 << SPARSE_UNIT), 4, 1'b0, 1'b0);
      run_phase(LSU_CYCLES, '1, 10, 1'b1, 1'b0);
      run_phase(SALU_CYCLES, '1, 10, 1'b1, 1'b1);
      run_phase(DRAIN_CYCLES, '0, 0, 1'b0, 1'b0);

      @(negedge clk);
      end_ok = (i_dut.entry_valid == '0);
      assert (end_ok) else
         $display("[FAIL] entry_valid 0x%h after the drain, expected 0x%h",
                  i_dut.entry_valid, N'(0));
      for (int i = 0; i < N; i++) begin
         assert (i_dut.i_sva.exp_seq[i] == push_seq[i]) else begin
            $display("[FAIL] writes of unit %0d 0x%h, expected 0x%h",
                     i, i_dut.i_sva.exp_seq[i], push_seq[i]);
            end_ok = 1'b0;
         end
      end
      if (!end_ok || (i_dut.i_sva.fail_count != 0)) begin
         stop_on_failure("results were missing at the end of the run");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/rfa_pkg.sv
wb_queue/wb_queue.sv
rfa/rfa.sv
src/rf_write_port.sv
src/wb_top.sv
verification/wb_tb_sva.sv
verification/wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wb_tb -f sim.f -o wb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Let every assertion report before the testbench stops the run
output=$(./obj_dir/wb_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
